//--- bench/tb_eth_commu.sv
`timescale 1ns/10ps
`include "eth_params.svh"

module tb_eth_commu;
	import eth_pkg::*;

	localparam int OVERHEAD = `PREAMBLE_LEN + `ETH_HDR_LEN + `IP_HDR_LEN + `UDP_HDR_LEN + 2;
	localparam int MAX_PAYLOAD = 64;
	localparam int TX_FRAMES = 6;
	localparam int RX_FRAMES = 7;
	localparam int RX_SLOT = `PREAMBLE_LEN + `RX_CAPTURE_LEN + 16;	// frame, gap and judge
	localparam int CYCLE_LIMIT = 20 * (TX_FRAMES * (OVERHEAD + MAX_PAYLOAD)
		+ RX_FRAMES * RX_SLOT + 16);
	localparam mac_addr_t BCAST_MAC = 48'hFFFF_FFFF_FFFF;
	localparam mac_addr_t OTHER_MAC = 48'h02_00_00_00_00_09;

	logic i_clk;
	logic i_rst_n;
	data_len_t i_data_length;
	byte_t i_pck_ident;
	byte_t i_pck_idx;
	byte_t i_cur_byte;
	logic i_trig_send;
	logic i_cmd_finish;
	logic i_eth_rxdv;
	byte_t i_eth_rxd;
	logic o_feed_next_byte;
	logic o_send_over;
	cmd_t o_cmd;
	param_t o_param;
	logic o_cmd_come;
	logic o_eth_txen;
	byte_t o_eth_txd;

	integer seed;
	int cycles = 0;
	int tx_idx = 0;
	int feed_cnt = 0;
	int frames_done = 0;
	logic cmd_expected = 1'b0;
	byte_t build_q[$];
	byte_t exp_frame[$];
	byte_t payload[$];

	eth_commu_top i_dut
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_data_length(i_data_length),
		.i_pck_ident(i_pck_ident),
		.i_pck_idx(i_pck_idx),
		.i_cur_byte(i_cur_byte),
		.i_trig_send(i_trig_send),
		.i_cmd_finish(i_cmd_finish),
		.i_eth_rxdv(i_eth_rxdv),
		.i_eth_rxd(i_eth_rxd),
		.o_feed_next_byte(o_feed_next_byte),
		.o_send_over(o_send_over),
		.o_cmd(o_cmd),
		.o_param(o_param),
		.o_cmd_come(o_cmd_come),
		.o_eth_txen(o_eth_txen),
		.o_eth_txd(o_eth_txd)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	always @(posedge i_clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
			stop_on_error($sformatf("timeout after %0d cycles, the DUT stopped responding",
				cycles));
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	// msb first as on the wire
	task automatic push_bytes(input logic [47:0] val, input int n);
		for (int k = n - 1; k >= 0; k--)
			build_q.push_back(val[k*8 +: 8]);
	endtask

	task automatic build_tx_frame(input int len);
		logic [15:0] udp_len;
		logic [15:0] ip_len;
		logic [31:0] sum;
		logic [15:0] csum;
		int ip_start;
		udp_len = 16'(len + 2 + `UDP_HDR_LEN);
		ip_len = udp_len + 16'(`IP_HDR_LEN);
		build_q.delete();
		for (int i = 0; i < `PREAMBLE_LEN - 1; i++)
			build_q.push_back(8'h55);
		build_q.push_back(8'hD5);
		push_bytes(48'(`DEST_MAC), 6);
		push_bytes(48'(`LOCAL_MAC), 6);
		push_bytes(48'(`ETHERTYPE_IPV4), 2);
		ip_start = build_q.size();
		push_bytes(48'({4'h4, 4'(`IP_HDR_LEN / 4), 8'h00}), 2);
		push_bytes(48'(ip_len), 2);
		push_bytes(48'(0), 4);	// identification, flags and offset
		push_bytes(48'({`IP_TTL, `IP_PROTO_UDP}), 2);
		push_bytes(48'(0), 2);
		push_bytes(48'(`LOCAL_IP), 4);
		push_bytes(48'(`DEST_IP), 4);
		sum = '0;
		for (int i = 0; i < `IP_HDR_LEN; i += 2)
			sum += {16'h0000, build_q[ip_start + i], build_q[ip_start + i + 1]};
		sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
		sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
		csum = ~sum[15:0];
		build_q[ip_start + 10] = csum[15:8];
		build_q[ip_start + 11] = csum[7:0];
		push_bytes(48'({`UDP_PORT, `UDP_PORT}), 4);
		push_bytes(48'({udp_len, 16'h0000}), 4);
		build_q.push_back(i_pck_ident);
		build_q.push_back(i_pck_idx);
		foreach (payload[i])
			build_q.push_back(payload[i]);
		exp_frame = build_q;
	endtask

	task automatic send_frame(input int len);
		int done_before;
		int feed_idx;
		logic fed;
		payload.delete();
		for (int i = 0; i < len; i++)
			payload.push_back(byte_t'($random(seed)));
		@(posedge i_clk);
		#1;
		i_data_length = data_len_t'(len);
		i_pck_ident = byte_t'($random(seed));
		i_pck_idx = byte_t'($random(seed));
		i_cur_byte = payload[0];
		build_tx_frame(len);
		done_before = frames_done;
		i_trig_send = 1'b1;
		@(posedge i_clk);
		#1;
		i_trig_send = 1'b0;
		feed_idx = 0;
		while (frames_done == done_before)
		begin
			@(negedge i_clk);
			fed = o_feed_next_byte;
			@(posedge i_clk);
			#1;
			if (fed && feed_idx + 1 < len)
			begin
				feed_idx++;
				i_cur_byte = payload[feed_idx];
			end
		end
	endtask

	task automatic send_rx_frame(input mac_addr_t dst, input logic bad_pre, input cmd_t cmd,
		input cmd_t chk, input param_t param);
		build_q.delete();
		for (int i = 0; i < `PREAMBLE_LEN - 1; i++)
			build_q.push_back(8'h55);
		build_q.push_back(8'hD5);
		if (bad_pre)
			build_q[3] = 8'h5D;
		push_bytes(48'(dst), 6);
		push_bytes(48'(`DEST_MAC), 6);
		push_bytes(48'(`ETHERTYPE_IPV4), 2);
		while (build_q.size() < `PREAMBLE_LEN + `CMD_OFFSET)
			build_q.push_back(byte_t'($random(seed)));	// ip and udp header bytes the parser skips
		push_bytes(48'(cmd), 2);
		push_bytes(48'(chk), 2);
		push_bytes(48'(param), 4);
		foreach (build_q[i])
		begin
			@(posedge i_clk);
			#1;
			i_eth_rxdv = 1'b1;
			i_eth_rxd = build_q[i];
		end
		@(posedge i_clk);
		#1;
		i_eth_rxdv = 1'b0;
		i_eth_rxd = 8'h00;
		repeat (12) @(negedge i_clk);
	endtask

	task automatic expect_command(input mac_addr_t dst, input cmd_t cmd, input param_t param);
		cmd_expected = 1'b1;
		send_rx_frame(dst, 1'b0, cmd, ~cmd, param);
		while (!o_cmd_come)
			@(negedge i_clk);
		assert (o_cmd == cmd)
		else stop_on_error($sformatf("[ERROR] o_cmd: got %h, expected %h", o_cmd, cmd));
		assert (o_param == param)
		else stop_on_error($sformatf("[ERROR] o_param: got %h, expected %h", o_param, param));
	endtask

	task automatic expect_drop(input mac_addr_t dst, input logic bad_pre, input cmd_t cmd,
		input cmd_t chk);
		send_rx_frame(dst, bad_pre, cmd, chk, param_t'($random(seed)));
		assert (!o_cmd_come)
		else stop_on_error($sformatf("[ERROR] o_cmd_come: got %h, expected 0", o_cmd_come));
	endtask

	task automatic release_command;
		@(posedge i_clk);
		#1;
		i_cmd_finish = 1'b1;
		@(posedge i_clk);
		#1;
		i_cmd_finish = 1'b0;
		@(negedge i_clk);
		assert (!o_cmd_come)
		else stop_on_error($sformatf("[ERROR] o_cmd_come after finish: got %h, expected 0",
			o_cmd_come));
		cmd_expected = 1'b0;
	endtask

	// tx byte stream against the model
	always @(negedge i_clk)
	if (i_rst_n)
	begin
		if (o_eth_txen)
		begin
			assert (tx_idx < exp_frame.size())
			else stop_on_error("o_eth_txen stayed high past the end of the frame");
			assert (o_eth_txd == exp_frame[tx_idx])
			else stop_on_error($sformatf("[ERROR] o_eth_txd byte %0d: got %h, expected %h",
				tx_idx, o_eth_txd, exp_frame[tx_idx]));
			tx_idx++;
		end
		if (o_feed_next_byte)
			feed_cnt++;
		if (o_send_over)
		begin
			assert (tx_idx == exp_frame.size())
			else stop_on_error($sformatf("[ERROR] o_eth_txen cycles: got %h, expected %h",
				tx_idx, exp_frame.size()));
			assert (feed_cnt == exp_frame.size() - OVERHEAD)
			else stop_on_error($sformatf("[ERROR] o_feed_next_byte cycles: got %h, expected %h",
				feed_cnt, exp_frame.size() - OVERHEAD));
			tx_idx = 0;
			feed_cnt = 0;
			frames_done++;
		end
	end

	// a gap in txen would fall early without send-over
	a_send_over: assert property (@(negedge i_clk) disable iff (!i_rst_n)
		o_send_over == $fell(o_eth_txen))
	else stop_on_error($sformatf("[ERROR] o_send_over: got %h with o_eth_txen %h",
		o_send_over, o_eth_txen));

	a_feed_in_frame: assert property (@(negedge i_clk) disable iff (!i_rst_n)
		o_feed_next_byte |-> o_eth_txen)
	else stop_on_error("o_feed_next_byte was high outside a frame");

	a_cmd_rise: assert property (@(negedge i_clk) disable iff (!i_rst_n)
		$rose(o_cmd_come) |-> cmd_expected)
	else stop_on_error($sformatf("[ERROR] o_cmd_come rose for a rejected frame, o_cmd %h",
		o_cmd));

	a_cmd_hold: assert property (@(negedge i_clk) disable iff (!i_rst_n)
		o_cmd_come && !i_cmd_finish |=> o_cmd_come && $stable(o_cmd) && $stable(o_param))
	else stop_on_error($sformatf(
		"[ERROR] held command changed: o_cmd_come %h o_cmd %h o_param %h",
		o_cmd_come, o_cmd, o_param));

	a_cmd_release: assert property (@(negedge i_clk) disable iff (!i_rst_n)
		o_cmd_come && i_cmd_finish |=> !o_cmd_come)
	else stop_on_error($sformatf("[ERROR] o_cmd_come after finish: got %h, expected 0",
		o_cmd_come));

	initial
	begin
		cmd_t cmd_a;
		param_t param_a;
		seed = 32'h092e_bed5;
		i_rst_n = 1'b0;
		i_data_length = '0;
		i_pck_ident = '0;
		i_pck_idx = '0;
		i_cur_byte = '0;
		i_trig_send = 1'b0;
		i_cmd_finish = 1'b0;
		i_eth_rxdv = 1'b0;
		i_eth_rxd = '0;
		repeat (16) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		@(negedge i_clk);
		assert (!o_eth_txen && !o_feed_next_byte && !o_send_over && !o_cmd_come)
		else stop_on_error($sformatf(
			"[ERROR] reset: o_eth_txen %h o_feed_next_byte %h o_send_over %h o_cmd_come %h",
			o_eth_txen, o_feed_next_byte, o_send_over, o_cmd_come));
		assert (o_cmd == '0 && o_param == '0)
		else stop_on_error($sformatf("[ERROR] reset: o_cmd %h o_param %h, expected 0",
			o_cmd, o_param));

		send_frame(1);
		send_frame(2);
		send_frame(MAX_PAYLOAD);
		repeat (TX_FRAMES - 3)
			send_frame(1 + int'($unsigned($random(seed)) % MAX_PAYLOAD));

		expect_command(`LOCAL_MAC, cmd_t'($random(seed)), param_t'($random(seed)));
		release_command();
		expect_command(BCAST_MAC, cmd_t'($random(seed)), param_t'($random(seed)));
		release_command();
		expect_drop(`LOCAL_MAC, 1'b0, 16'h1234, 16'h1234);	// check word not inverted
		expect_drop(OTHER_MAC, 1'b0, 16'h00A5, 16'hFF5A);
		expect_drop(`LOCAL_MAC, 1'b1, 16'h00A5, 16'hFF5A);

		// second command while the first is held
		cmd_a = cmd_t'($random(seed));
		param_a = param_t'($random(seed));
		expect_command(`LOCAL_MAC, cmd_a, param_a);
		send_rx_frame(`LOCAL_MAC, 1'b0, ~cmd_a, cmd_a, ~param_a);
		assert (o_cmd_come && o_cmd == cmd_a && o_param == param_a)
		else stop_on_error($sformatf(
			"[ERROR] held command: o_cmd_come %h o_cmd %h o_param %h, expected 1 %h %h",
			o_cmd_come, o_cmd, o_param, cmd_a, param_a));
		release_command();

		repeat (10) @(posedge i_clk);
		$display("** PASS **");
		$finish;
	end

endmodule

//--- design/eth_commu_ctrl.sv
`timescale 1ns/10ps

module eth_commu_ctrl
(
	input                   i_clk,
	input                   i_rst_n,
	input                   i_trig_send,
	input                   i_hdr_ready,
	input                   i_tx_done,
	input                   i_cmd_valid,
	input  eth_pkg::rx_cmd_t i_rx_cmd,
	input                   i_cmd_finish,
	output logic            o_prep_start,
	output logic            o_tx_start,
	output logic            o_send_over,
	output eth_pkg::cmd_t   o_cmd,
	output eth_pkg::param_t o_param,
	output logic            o_cmd_come
);
	import eth_pkg::*;

	tx_state_e tx_state;
	logic trig_q;
	logic trig_rise;
	logic send_pend;

	assign trig_rise = i_trig_send & ~trig_q;

	// one cycle in done is the send-over pulse
	assign o_send_over = (tx_state == TX_DONE);

	always_ff @(posedge i_clk or negedge i_rst_n)
	if (!i_rst_n)
	begin
		trig_q <= 1'b0;
		send_pend <= 1'b0;
	end
	else
	begin
		trig_q <= i_trig_send;
		if (trig_rise)
			send_pend <= 1'b1;	// held while a send is running
		else if (tx_state == TX_IDLE)
			send_pend <= 1'b0;
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	if (!i_rst_n)
	begin
		tx_state <= TX_IDLE;
		o_prep_start <= 1'b0;
		o_tx_start <= 1'b0;
	end
	else
	begin
		o_prep_start <= 1'b0;
		o_tx_start <= 1'b0;
		case (tx_state)
		TX_IDLE:
			if (send_pend)
			begin
				tx_state <= TX_PREP;
				o_prep_start <= 1'b1;
			end
		TX_PREP:
			if (i_hdr_ready)
			begin
				tx_state <= TX_SEND;
				o_tx_start <= 1'b1;
			end
		TX_SEND:
			if (i_tx_done)	// framer is on its last byte
				tx_state <= TX_DONE;
		TX_DONE:
			tx_state <= TX_IDLE;
		default:
			tx_state <= TX_IDLE;
		endcase
	end

	// command hold until the user reports it finished
	always_ff @(posedge i_clk or negedge i_rst_n)
	if (!i_rst_n)
	begin
		o_cmd <= '0;
		o_param <= '0;
		o_cmd_come <= 1'b0;
	end
	else
	begin
		if (o_cmd_come)
		begin
			if (i_cmd_finish)
				o_cmd_come <= 1'b0;
		end
		else if (i_cmd_valid)
		begin
			o_cmd <= i_rx_cmd.cmd;
			o_param <= i_rx_cmd.param;
			o_cmd_come <= 1'b1;
		end
	end

endmodule

//--- design/eth_commu_top.sv
`timescale 1ns/10ps

module eth_commu_top
(
	input                       i_clk,
	input                       i_rst_n,
	input  eth_pkg::data_len_t  i_data_length,
	input  eth_pkg::byte_t      i_pck_ident,
	input  eth_pkg::byte_t      i_pck_idx,
	input  eth_pkg::byte_t      i_cur_byte,
	input                       i_trig_send,
	input                       i_cmd_finish,
	input                       i_eth_rxdv,
	input  eth_pkg::byte_t      i_eth_rxd,
	output logic                o_feed_next_byte,
	output logic                o_send_over,
	output eth_pkg::cmd_t       o_cmd,
	output eth_pkg::param_t     o_param,
	output logic                o_cmd_come,
	output logic                o_eth_txen,
	output eth_pkg::byte_t      o_eth_txd
);
	import eth_pkg::*;

	logic prep_start;
	logic hdr_ready;
	logic tx_start;
	logic tx_done;
	logic cmd_valid;
	hdr_fields_t hdr;
	rx_cmd_t rx_cmd;

	eth_commu_ctrl u_ctrl
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_trig_send(i_trig_send),
		.i_hdr_ready(hdr_ready),
		.i_tx_done(tx_done),
		.i_cmd_valid(cmd_valid),
		.i_rx_cmd(rx_cmd),
		.i_cmd_finish(i_cmd_finish),
		.o_prep_start(prep_start),
		.o_tx_start(tx_start),
		.o_send_over(o_send_over),
		.o_cmd(o_cmd),
		.o_param(o_param),
		.o_cmd_come(o_cmd_come)
	);

	udp_ip_hdr_gen u_hdr_gen
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_start(prep_start),
		.i_data_length(i_data_length),
		.o_hdr(hdr),
		.o_ready(hdr_ready)
	);

	mac_tx_framer u_framer
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_start(tx_start),
		.i_hdr(hdr),
		.i_data_length(i_data_length),
		.i_pck_ident(i_pck_ident),
		.i_pck_idx(i_pck_idx),
		.i_cur_byte(i_cur_byte),
		.o_feed_next_byte(o_feed_next_byte),
		.o_done(tx_done),
		.o_eth_txen(o_eth_txen),
		.o_eth_txd(o_eth_txd)
	);

	rx_frame_parser u_rx_parser
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_eth_rxdv(i_eth_rxdv),
		.i_eth_rxd(i_eth_rxd),
		.o_cmd_valid(cmd_valid),
		.o_rx_cmd(rx_cmd)
	);

endmodule

//--- design/eth_params.svh
`ifndef ETH_PARAMS_SVH
`define ETH_PARAMS_SVH

// station addresses fixed at build time
`define LOCAL_MAC       48'h02_00_00_00_00_04
`define DEST_MAC        48'h08_62_66_B3_84_1C
`define LOCAL_IP        32'hC0_A8_01_04
`define DEST_IP         32'hC0_A8_01_05

// same port on both ends
`define UDP_PORT        16'hFEEF

`define IP_TTL          8'h80
`define IP_PROTO_UDP    8'h11
`define ETHERTYPE_IPV4  16'h0800

// lengths in bytes
`define PREAMBLE_LEN    8
`define ETH_HDR_LEN     14
`define IP_HDR_LEN      20
`define UDP_HDR_LEN     8

// rx offsets counted from the first byte after the SFD
`define CMD_OFFSET      42
`define RX_CAPTURE_LEN  50

`endif

//--- design/eth_pkg.sv
package eth_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ipv4_addr_t;
	typedef logic [10:0] data_len_t;	// payload bytes without ident and idx
	typedef logic [15:0] cmd_t;
	typedef logic [31:0] param_t;

	// per-send header words computed before the frame goes out
	typedef struct packed
	{
		logic [15:0] udp_len;
		logic [15:0] ip_total_len;
		logic [15:0] ip_csum;
	} hdr_fields_t;

	typedef struct packed
	{
		cmd_t   cmd;
		param_t param;
	} rx_cmd_t;

	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_PREP,
		TX_SEND,
		TX_DONE
	} tx_state_e;

	typedef enum logic [2:0]
	{
		RX_IDLE,
		RX_PREAMBLE,
		RX_STORE,
		RX_ERROR,
		RX_JUDGE
	} rx_state_e;

endpackage

//--- design/mac_tx_framer.sv
`timescale 1ns/10ps
`include "eth_params.svh"

module mac_tx_framer
(
	input                        i_clk,
	input                        i_rst_n,
	input                        i_start,
	input  eth_pkg::hdr_fields_t i_hdr,
	input  eth_pkg::data_len_t   i_data_length,
	input  eth_pkg::byte_t       i_pck_ident,
	input  eth_pkg::byte_t       i_pck_idx,
	input  eth_pkg::byte_t       i_cur_byte,
	output logic                 o_feed_next_byte,
	output logic                 o_done,
	output logic                 o_eth_txen,
	output eth_pkg::byte_t       o_eth_txd
);
	import eth_pkg::*;

	localparam int PRE_LEN = `PREAMBLE_LEN;
	localparam int HDR_BYTES = `ETH_HDR_LEN + `IP_HDR_LEN + `UDP_HDR_LEN;
	localparam logic [11:0] ID_POS = 12'(PRE_LEN + HDR_BYTES);
	localparam logic [11:0] PAY_POS = ID_POS + 12'd2;
	localparam logic [7:0] VER_IHL = {4'h4, 4'(`IP_HDR_LEN / 4)};
	localparam mac_addr_t SRC_MAC = `LOCAL_MAC;
	localparam mac_addr_t DST_MAC = `DEST_MAC;
	localparam ipv4_addr_t SRC_IP = `LOCAL_IP;
	localparam ipv4_addr_t DST_IP = `DEST_IP;

	logic run;
	logic load;
	logic [11:0] pos;	// index of the byte loaded next
	logic [11:0] cur_pos;
	logic [11:0] last_pos;
	logic [5:0] hdr_idx;
	logic [HDR_BYTES*8-1:0] hdr_vec;
	byte_t tx_byte;

	// eth + ip + udp headers with the first wire byte in the top bits
	assign hdr_vec = {DST_MAC, SRC_MAC, `ETHERTYPE_IPV4,
		VER_IHL, 8'h00, i_hdr.ip_total_len, 16'h0000, 16'h0000,
		`IP_TTL, `IP_PROTO_UDP, i_hdr.ip_csum, SRC_IP, DST_IP,
		`UDP_PORT, `UDP_PORT, i_hdr.udp_len, 16'h0000};

	assign cur_pos = run ? pos : 12'd0;
	assign load = run | i_start;
	assign hdr_idx = 6'(cur_pos - 12'(PRE_LEN));
	assign o_feed_next_byte = run && (pos >= PAY_POS);

	always_comb
	begin
		if (cur_pos < 12'(PRE_LEN))
			tx_byte = (cur_pos == 12'(PRE_LEN - 1)) ? 8'hD5 : 8'h55;	// sfd last
		else if (cur_pos < ID_POS)
			tx_byte = hdr_vec[(HDR_BYTES - 1 - int'(hdr_idx)) * 8 +: 8];
		else if (cur_pos == ID_POS)
			tx_byte = i_pck_ident;
		else if (cur_pos == ID_POS + 12'd1)
			tx_byte = i_pck_idx;
		else
			tx_byte = i_cur_byte;
	end

	always_ff @(posedge i_clk)
	if (i_start && !run)
		last_pos <= PAY_POS + 12'(i_data_length) - 12'd1;

	always_ff @(posedge i_clk or negedge i_rst_n)
	if (!i_rst_n)
	begin
		run <= 1'b0;
		pos <= '0;
		o_done <= 1'b0;
		o_eth_txen <= 1'b0;
		o_eth_txd <= '0;
	end
	else
	begin
		o_done <= 1'b0;
		o_eth_txen <= load;
		o_eth_txd <= load ? tx_byte : 8'h00;
		if (run)
		begin
			pos <= pos + 12'd1;
			if (pos == last_pos)
			begin
				run <= 1'b0;
				o_done <= 1'b1;	// high with the last byte
			end
		end
		else if (i_start)
		begin
			run <= 1'b1;
			pos <= 12'd1;
		end
	end

endmodule

//--- design/rx_frame_parser.sv
`timescale 1ns/10ps
`include "eth_params.svh"

module rx_frame_parser
(
	input                    i_clk,
	input                    i_rst_n,
	input                    i_eth_rxdv,
	input  eth_pkg::byte_t   i_eth_rxd,
	output logic             o_cmd_valid,
	output eth_pkg::rx_cmd_t o_rx_cmd
);
	import eth_pkg::*;

	localparam logic [2:0] PRE_LAST = 3'(`PREAMBLE_LEN - 1);
	localparam logic [5:0] MAC_BYTES = 6'($bits(mac_addr_t) / 8);
	localparam logic [5:0] TYPE_POS = 6'(`ETH_HDR_LEN - 2);
	localparam logic [5:0] CMD_POS = 6'(`CMD_OFFSET);
	localparam logic [5:0] CHK_POS = CMD_POS + 6'd2;
	localparam logic [5:0] PARAM_POS = CMD_POS + 6'd4;
	localparam logic [5:0] CAP_LEN = 6'(`RX_CAPTURE_LEN);
	localparam mac_addr_t OWN_MAC = `LOCAL_MAC;

	rx_state_e rx_state;
	byte_t rxd_q;
	logic [2:0] pre_cnt;
	logic [5:0] store_idx;
	mac_addr_t dst_mac;
	logic [15:0] eth_type;
	cmd_t chk_word;
	rx_cmd_t cmd_q;
	logic accept;

	assign accept = ((dst_mac == OWN_MAC) || (&dst_mac))
		&& (eth_type == `ETHERTYPE_IPV4)
		&& (cmd_q.cmd == ~chk_word)
		&& (store_idx == CAP_LEN);	// short frames are dropped

	assign o_cmd_valid = (rx_state == RX_JUDGE) && accept;
	assign o_rx_cmd = cmd_q;

	always_ff @(posedge i_clk)
		rxd_q <= i_eth_rxd;

	always_ff @(posedge i_clk or negedge i_rst_n)
	if (!i_rst_n)
	begin
		rx_state <= RX_IDLE;
		pre_cnt <= '0;
		store_idx <= '0;
	end
	else
	begin
		case (rx_state)
		RX_IDLE:
			if (i_eth_rxdv)
			begin
				rx_state <= RX_PREAMBLE;
				pre_cnt <= '0;
				store_idx <= '0;
			end
		RX_PREAMBLE:
		begin
			pre_cnt <= pre_cnt + 3'd1;
			if (!i_eth_rxdv)
				rx_state <= RX_IDLE;
			else if (pre_cnt == PRE_LAST)
				rx_state <= (rxd_q == 8'hD5) ? RX_STORE : RX_ERROR;
			else if (rxd_q != 8'h55)
				rx_state <= RX_ERROR;
		end
		RX_STORE:
		begin
			if (!i_eth_rxdv)
				rx_state <= RX_JUDGE;	// rxd_q still holds the last byte
			if (store_idx != CAP_LEN)
				store_idx <= store_idx + 6'd1;
		end
		RX_ERROR:
			if (!i_eth_rxdv)
				rx_state <= RX_IDLE;
		RX_JUDGE:
			rx_state <= RX_IDLE;
		default:
			rx_state <= RX_IDLE;
		endcase
	end

	// fields are shifted in as their bytes pass
	always_ff @(posedge i_clk)
	if (rx_state == RX_STORE && store_idx != CAP_LEN)
	begin
		if (store_idx < MAC_BYTES)
			dst_mac <= {dst_mac[39:0], rxd_q};
		else if (store_idx == TYPE_POS || store_idx == TYPE_POS + 6'd1)
			eth_type <= {eth_type[7:0], rxd_q};
		else if (store_idx == CMD_POS || store_idx == CMD_POS + 6'd1)
			cmd_q.cmd <= {cmd_q.cmd[7:0], rxd_q};
		else if (store_idx == CHK_POS || store_idx == CHK_POS + 6'd1)
			chk_word <= {chk_word[7:0], rxd_q};
		else if (store_idx >= PARAM_POS)
			cmd_q.param <= {cmd_q.param[23:0], rxd_q};
	end

endmodule

//--- design/udp_ip_hdr_gen.sv
`timescale 1ns/10ps
`include "eth_params.svh"

module udp_ip_hdr_gen
(
	input                        i_clk,
	input                        i_rst_n,
	input                        i_start,
	input  eth_pkg::data_len_t   i_data_length,
	output eth_pkg::hdr_fields_t o_hdr,
	output logic                 o_ready
);
	import eth_pkg::*;

	localparam logic [7:0] VER_IHL = {4'h4, 4'(`IP_HDR_LEN / 4)};
	localparam ipv4_addr_t SRC_IP = `LOCAL_IP;
	localparam ipv4_addr_t DST_IP = `DEST_IP;

	logic [15:0] udp_len_c;
	logic [15:0] ip_len_c;
	logic [19:0] sum_c;
	logic [19:0] sum_q;
	logic [15:0] udp_len_q;
	logic [15:0] ip_len_q;
	logic [16:0] fold1;
	logic [15:0] fold2;
	logic sum_vld;

	// payload plus the two ident bytes
	assign udp_len_c = 16'(i_data_length) + 16'd2 + 16'(`UDP_HDR_LEN);
	assign ip_len_c = udp_len_c + 16'(`IP_HDR_LEN);

	// ident, flags/frag and checksum words are zero and drop out
	assign sum_c = 20'({VER_IHL, 8'h00}) + 20'(ip_len_c)
		+ 20'({`IP_TTL, `IP_PROTO_UDP})
		+ 20'(SRC_IP[31:16]) + 20'(SRC_IP[15:0])
		+ 20'(DST_IP[31:16]) + 20'(DST_IP[15:0]);

	assign fold1 = {1'b0, sum_q[15:0]} + 17'(sum_q[19:16]);
	assign fold2 = fold1[15:0] + 16'(fold1[16]);

	always_ff @(posedge i_clk or negedge i_rst_n)
	if (!i_rst_n)
	begin
		sum_vld <= 1'b0;
		o_ready <= 1'b0;
	end
	else
	begin
		sum_vld <= i_start;
		o_ready <= sum_vld;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_start)
		begin
			sum_q <= sum_c;
			udp_len_q <= udp_len_c;
			ip_len_q <= ip_len_c;
		end
		if (sum_vld)
			o_hdr <= '{udp_len: udp_len_q, ip_total_len: ip_len_q, ip_csum: ~fold2};
	end

endmodule

//--- flist.f
+incdir+design
design/eth_pkg.sv
design/eth_commu_ctrl.sv
design/udp_ip_hdr_gen.sv
design/mac_tx_framer.sv
design/rx_frame_parser.sv
design/eth_commu_top.sv
bench/tb_eth_commu.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_eth_commu \
	-f flist.f -o tb_eth_commu > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_eth_commu > sim.log 2>&1
grep -q "\*\* FAIL \*\*" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "\*\* PASS \*\*" sim.log || { echo "simulation ended early, see sim.log"; exit 1; }
echo "simulation passed"
